// File: Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only --timing -Wall
TOP       := cnn_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test FAILED" $(LOG) || ! grep -q "Test OK" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: build.f
common/cnn_pkg.sv
common/host_pkg.sv
src/stream_fifo.sv
src/job_loader.sv
cores/conv_3x3.sv
cores/pool_3x3.sv
src/cnn_top.sv
test/cnn_top_assert.sv
test/cnn_tb.sv

// File: common/cnn_pkg.sv
`default_nettype none

package cnn_pkg;

	//--------------------------------------------------
	// Fixed point data
	//--------------------------------------------------
	typedef logic signed [15:0] pixel_t;        // Q8.8

	// Row-major 3x3 window with the top-left pixel in element 0
	typedef pixel_t [8:0] window_t;

	typedef enum logic {
		OP_CONV = 1'b0,
		OP_POOL = 1'b1
	} op_e;

	//--------------------------------------------------
	// Core job and result
	//--------------------------------------------------
	typedef struct packed {
		op_e     op;
		window_t pixels;
		window_t weights;                       // Ignored by the pooling core
		pixel_t  bias;
	} job_t;

	typedef struct packed {
		logic   valid;
		op_e    op;
		pixel_t value;
	} core_out_t;

	// Nine Q16.16 products with headroom for the sum
	localparam int ACC_W = 36;

endpackage

`default_nettype wire

// File: common/host_pkg.sv
`default_nettype none

package host_pkg;

	typedef logic [31:0] word_t;

	// First word of a job block
	typedef struct packed {
		logic [14:0]     rsvd;
		cnn_pkg::op_e    op;                    // Bit 16
		cnn_pkg::pixel_t bias;
	} header_t;

	// Words two to ten of a block carry one window position each
	typedef struct packed {
		cnn_pkg::pixel_t pixel;
		cnn_pkg::pixel_t weight;
	} operand_t;

	// Word returned to the host per job
	typedef struct packed {
		logic [14:0]     rsvd;
		cnn_pkg::op_e    op;
		cnn_pkg::pixel_t value;
	} result_t;

	localparam int JOB_WORDS = 10;              // Header plus nine operands

endpackage

`default_nettype wire

// File: cores/conv_3x3.sv
`timescale 1ns/1ns
`default_nettype none

module conv_3x3 (
	input  wire                okClk,
	input  wire                rst_n,
	input  wire                issue,
	input  wire cnn_pkg::job_t job,
	output cnn_pkg::core_out_t result
);

	localparam int ACC_W  = cnn_pkg::ACC_W;
	localparam int PROD_W = 2 * $bits(cnn_pkg::pixel_t);
	localparam logic signed [ACC_W-1:0] SAT_MAX = 32767;
	localparam logic signed [ACC_W-1:0] SAT_MIN = -32768;

	// Valid per stage
	logic                     v1_q;
	logic                     v2_q;
	logic                     v3_q;
	cnn_pkg::op_e             op1_q;
	cnn_pkg::op_e             op2_q;
	cnn_pkg::op_e             op3_q;
	cnn_pkg::pixel_t          bias1_q;
	cnn_pkg::pixel_t          bias2_q;
	logic signed [PROD_W-1:0] prod_q [9];
	logic signed [ACC_W-1:0]  row_q [3];
	logic signed [ACC_W-1:0]  sum_full;
	logic signed [ACC_W-1:0]  scaled;
	cnn_pkg::pixel_t          sat_val;
	cnn_pkg::pixel_t          val3_q;

	always_ff @(posedge okClk or negedge rst_n) begin
		if (!rst_n) begin
			v1_q <= 1'b0;
			v2_q <= 1'b0;
			v3_q <= 1'b0;
		end else begin
			v1_q <= issue;
			v2_q <= v1_q;
			v3_q <= v2_q;
		end
	end

	//--------------------------------------------------
	// Stages 1 and 2 form products then row sums
	//--------------------------------------------------
	always_ff @(posedge okClk) begin
		for (int i = 0; i < 9; i++) begin
			prod_q[i] <= $signed(job.pixels[i]) * $signed(job.weights[i]); // Q16.16
		end
		op1_q   <= job.op;
		bias1_q <= job.bias;

		for (int r = 0; r < 3; r++) begin
			row_q[r] <= prod_q[3*r] + prod_q[3*r+1] + prod_q[3*r+2];
		end
		op2_q   <= op1_q;
		bias2_q <= bias1_q;
	end

	//--------------------------------------------------
	// Stage 3 rescales, adds the bias and saturates
	//--------------------------------------------------
	always_comb begin
		sum_full = row_q[0] + row_q[1] + row_q[2];
		scaled   = (sum_full >>> 8) + bias2_q; // Back to Q8.8 rounding toward minus infinity
		if (scaled > SAT_MAX) begin
			sat_val = 16'sh7fff;
		end else if (scaled < SAT_MIN) begin
			sat_val = 16'sh8000;
		end else begin
			sat_val = scaled[15:0];
		end
	end

	always_ff @(posedge okClk) begin
		op3_q  <= op2_q;
		val3_q <= sat_val;
	end

	assign result = '{valid: v3_q, op: op3_q, value: val3_q};

endmodule

`default_nettype wire

// File: cores/pool_3x3.sv
`timescale 1ns/1ns
`default_nettype none

module pool_3x3 (
	input  wire                okClk,
	input  wire                rst_n,
	input  wire                issue,
	input  wire cnn_pkg::job_t job,
	output cnn_pkg::core_out_t result
);

	logic            v1_q;
	logic            v2_q;
	logic            v3_q;
	cnn_pkg::op_e    op1_q;
	cnn_pkg::op_e    op2_q;
	cnn_pkg::op_e    op3_q;
	cnn_pkg::pixel_t m1_q [5];                  // Pair maxima plus the odd pixel
	cnn_pkg::pixel_t m2_q [3];
	cnn_pkg::pixel_t max_q;

	function automatic cnn_pkg::pixel_t smax(input cnn_pkg::pixel_t a,
		input cnn_pkg::pixel_t b);
		return (a > b) ? a : b;                 // Signed compare
	endfunction

	always_ff @(posedge okClk or negedge rst_n) begin
		if (!rst_n) begin
			v1_q <= 1'b0;
			v2_q <= 1'b0;
			v3_q <= 1'b0;
		end else begin
			v1_q <= issue;
			v2_q <= v1_q;
			v3_q <= v2_q;
		end
	end

	//--------------------------------------------------
	// Compare tree from 9 to 5 to 3 to 1
	//--------------------------------------------------
	always_ff @(posedge okClk) begin
		for (int i = 0; i < 4; i++) begin
			m1_q[i] <= smax(job.pixels[2*i], job.pixels[2*i+1]);
		end
		m1_q[4] <= job.pixels[8];
		op1_q   <= job.op;

		m2_q[0] <= smax(m1_q[0], m1_q[1]);
		m2_q[1] <= smax(m1_q[2], m1_q[3]);
		m2_q[2] <= m1_q[4];
		op2_q   <= op1_q;

		max_q <= smax(smax(m2_q[0], m2_q[1]), m2_q[2]);
		op3_q <= op2_q;
	end

	assign result = '{valid: v3_q, op: op3_q, value: max_q};

endmodule

`default_nettype wire

// File: src/cnn_top.sv
`timescale 1ns/1ns
`default_nettype none

module cnn_top #(
	parameter int IN_DEPTH  = 32,
	parameter int OUT_DEPTH = 8
) (
	input  wire                  okClk,
	input  wire                  rst_n,
	input  wire                  in_valid,
	input  wire host_pkg::word_t in_data,
	output logic                 in_block_ready,
	output logic                 out_valid,
	output host_pkg::result_t    out_data,
	input  wire                  out_ready
);

	// The registered flag trails the count by one push
	localparam int THROTTLE_HEADROOM = 1;

	logic                               in_empty;
	logic [$clog2(IN_DEPTH + 1)-1:0]    in_free;
	logic                               word_pop;
	host_pkg::word_t                    word_data;
	logic                               issue_conv;
	logic                               issue_pool;
	cnn_pkg::job_t                      job;
	cnn_pkg::core_out_t                 conv_out;
	cnn_pkg::core_out_t                 pool_out;
	cnn_pkg::core_out_t                 core_sel;
	logic                               res_push;
	host_pkg::result_t                  res_data;
	logic                               out_empty;
	logic [$clog2(OUT_DEPTH + 1)-1:0]   out_free;
	logic                               out_pop;

	//--------------------------------------------------
	// Host input side
	//--------------------------------------------------
	stream_fifo #(.DEPTH(IN_DEPTH), .payload_t(host_pkg::word_t)) u_in_fifo (
		.okClk     (okClk),
		.rst_n     (rst_n),
		.push      (in_valid),
		.push_data (in_data),
		.pop       (word_pop),
		.pop_data  (word_data),
		.empty     (in_empty),
		.free      (in_free)
	);

	// Block throttle flags room for a whole block
	always_ff @(posedge okClk or negedge rst_n) begin
		if (!rst_n) begin
			in_block_ready <= 1'b0;
		end else begin
			in_block_ready <= (in_free >= host_pkg::JOB_WORDS + THROTTLE_HEADROOM);
		end
	end

	job_loader #(.OUT_DEPTH(OUT_DEPTH)) u_job_loader (
		.okClk         (okClk),
		.rst_n         (rst_n),
		.word_empty    (in_empty),
		.word_data     (word_data),
		.word_pop      (word_pop),
		.credit_return (out_pop),
		.issue_conv    (issue_conv),
		.issue_pool    (issue_pool),
		.job           (job)
	);

	conv_3x3 u_conv_3x3 (.okClk(okClk), .rst_n(rst_n), .issue(issue_conv), .job(job),
		.result(conv_out));

	pool_3x3 u_pool_3x3 (.okClk(okClk), .rst_n(rst_n), .issue(issue_pool), .job(job),
		.result(pool_out));

	//--------------------------------------------------
	// Result merge and host output side
	//--------------------------------------------------
	// Equal core latency leaves at most one valid per cycle
	assign core_sel = conv_out.valid ? conv_out : pool_out;
	assign res_push = conv_out.valid || pool_out.valid;
	assign res_data = '{rsvd: '0, op: core_sel.op, value: core_sel.value};

	assign out_valid = !out_empty;
	assign out_pop   = out_valid && out_ready;  // Also returns a credit

	stream_fifo #(.DEPTH(OUT_DEPTH), .payload_t(host_pkg::result_t)) u_out_fifo (
		.okClk     (okClk),
		.rst_n     (rst_n),
		.push      (res_push),
		.push_data (res_data),
		.pop       (out_pop),
		.pop_data  (out_data),
		.empty     (out_empty),
		.free      (out_free)
	);

endmodule

`default_nettype wire

// File: src/job_loader.sv
`timescale 1ns/1ns
`default_nettype none

module job_loader #(
	parameter int OUT_DEPTH = 8
) (
	input  wire                  okClk,
	input  wire                  rst_n,
	input  wire                  word_empty,
	input  wire host_pkg::word_t word_data,
	output logic                 word_pop,
	input  wire                  credit_return,  // One result left the output FIFO
	output logic                 issue_conv,
	output logic                 issue_pool,
	output cnn_pkg::job_t        job
);

	localparam int CNT_W = $clog2(host_pkg::JOB_WORDS);
	localparam int CRW   = $clog2(OUT_DEPTH + 1);

	logic [CNT_W-1:0]   word_cnt;               // Position within the block
	logic               job_ready;              // Complete job waiting for a credit
	logic [CRW-1:0]     credits;
	logic               can_issue;
	logic               last_word;
	host_pkg::header_t  hdr;
	host_pkg::operand_t opd;

	// Same word seen through both layouts
	assign hdr = word_data;
	assign opd = word_data;

	assign can_issue  = job_ready && (credits != '0);
	assign issue_conv = can_issue && (job.op == cnn_pkg::OP_CONV);
	assign issue_pool = can_issue && (job.op == cnn_pkg::OP_POOL);

	// The cores sample the job on the issue edge, so the next block may start loading
	assign word_pop  = !word_empty && (!job_ready || can_issue);
	assign last_word = (word_cnt == CNT_W'(host_pkg::JOB_WORDS - 1));

	//--------------------------------------------------
	// Block assembly
	//--------------------------------------------------
	always_ff @(posedge okClk) begin
		if (word_pop) begin
			if (word_cnt == '0) begin
				job.op   <= hdr.op;
				job.bias <= hdr.bias;
			end else begin
				// First operand ends up in element 0
				job.pixels  <= {opd.pixel, job.pixels[8:1]};
				job.weights <= {opd.weight, job.weights[8:1]};
			end
		end
	end

	always_ff @(posedge okClk or negedge rst_n) begin
		if (!rst_n) begin
			word_cnt  <= '0;
			job_ready <= 1'b0;
		end else begin
			if (can_issue) begin
				job_ready <= 1'b0;
			end
			if (word_pop) begin
				if (last_word) begin
					word_cnt  <= '0;
					job_ready <= 1'b1;          // Issue can follow in the next cycle
				end else begin
					word_cnt <= word_cnt + 1'b1;
				end
			end
		end
	end

	//--------------------------------------------------
	// Output credits
	//--------------------------------------------------
	// One credit per free output slot not yet claimed by a job in flight
	always_ff @(posedge okClk or negedge rst_n) begin
		if (!rst_n) begin
			credits <= CRW'(OUT_DEPTH);
		end else begin
			case ({can_issue, credit_return})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/stream_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module stream_fifo #(
	parameter int DEPTH = 16,
	parameter type payload_t = logic [31:0],
	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1,
	localparam int CW = $clog2(DEPTH + 1)
) (
	input  wire            okClk,
	input  wire            rst_n,
	input  wire            push,
	input  wire payload_t  push_data,
	input  wire            pop,
	output payload_t       pop_data,
	output logic           empty,
	output logic [CW-1:0]  free
);

	payload_t      mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;                       // Words held
	logic          do_push;
	logic          do_pop;

	// Pointer step with wrap for any depth
	function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
		return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign do_push  = push && (count != CW'(DEPTH)); // Word lost when full
	assign do_pop   = pop && !empty;
	assign empty    = (count == '0);
	assign free     = CW'(DEPTH) - count;
	assign pop_data = mem[rd_ptr];              // Head of queue is valid while not empty

	always_ff @(posedge okClk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	//--------------------------------------------------
	// Pointers and occupancy
	//--------------------------------------------------
	always_ff @(posedge okClk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;            // Idle or push and pop together
			endcase
		end
	end

endmodule

`default_nettype wire

// File: test/cnn_tb.sv
`timescale 1ns/1ns
`default_nettype none

module cnn_tb;

	localparam int SEED          = 31889;
	localparam int N_TESTS       = 48;
	localparam int READY_TIMEOUT = 1000;     // Longer than any out_ready low stretch
	localparam int DRAIN_TIMEOUT = 20000;

	// Uniform conv windows as pixel then weight then bias
	localparam logic [47:0] FIXED_CONV [4] = '{
		48'h0100_0080_ff00,                     // 1.0 times 0.5 nine times minus 1.0
		48'hffff_0001_0000,                     // -9/65536 floors to -1/256
		48'h7fff_7fff_7fff,                     // Far past the upper rail
		48'h7fff_8000_8000                      // Far past the lower rail
	};

	typedef struct packed {
		cnn_pkg::op_e     op;
		cnn_pkg::window_t pixels;
		cnn_pkg::window_t weights;
		cnn_pkg::pixel_t  bias;
		cnn_pkg::pixel_t  result;               // Expected core output
	} entry_t;

	logic              okClk;
	logic              rst_n;
	logic              in_valid;
	host_pkg::word_t   in_data;
	logic              in_block_ready;
	logic              out_valid;
	host_pkg::result_t out_data;
	logic              out_ready;

	entry_t test_tab [N_TESTS];
	integer seed            = SEED;
	integer ready_seed      = SEED;
	int     rx_idx          = 0;
	int     errors          = 0;
	bit     throttle_opened = 1'b0;
	bit     throttle_closed = 1'b0;

	cnn_top #(.IN_DEPTH(32), .OUT_DEPTH(8)) u_cnn_top (
		.okClk(okClk), .rst_n(rst_n), .in_valid(in_valid), .in_data(in_data),
		.in_block_ready(in_block_ready), .out_valid(out_valid), .out_data(out_data),
		.out_ready(out_ready)
	);

	initial begin : clock_gen
		okClk = 1'b0;
		forever begin
			#50 okClk = ~okClk;
		end
	end

	// Q8.8 MAC floored by 256 plus bias and clamped, or else the signed maximum
	function automatic cnn_pkg::pixel_t expected_value(input entry_t e);
		logic signed [cnn_pkg::ACC_W-1:0] acc;
		cnn_pkg::pixel_t                  best;
		acc  = '0;
		best = e.pixels[0];
		for (int i = 0; i < 9; i++) begin
			acc = acc + $signed(e.pixels[i]) * $signed(e.weights[i]);
			if ($signed(e.pixels[i]) > $signed(best)) begin
				best = e.pixels[i];
			end
		end
		acc = (acc >>> 8) + $signed(e.bias);
		if (e.op == cnn_pkg::OP_POOL) begin
			return best;
		end else if (acc > 32767) begin
			return 16'sh7fff;
		end else if (acc < -32768) begin
			return 16'sh8000;
		end
		return acc[15:0];
	endfunction

	task automatic build_table();
		entry_t e;
		for (int t = 0; t < N_TESTS; t++) begin
			e.op   = cnn_pkg::op_e'($random(seed) & 1);
			e.bias = 16'($random(seed) % 4096);
			for (int i = 0; i < 9; i++) begin
				e.pixels[i]  = (t % 2 == 1) ? 16'($random(seed) % 1024) : 16'($random(seed));
				e.weights[i] = (t % 2 == 1) ? 16'($random(seed) % 1024) : 16'($random(seed));
				if (t < 4) begin
					e.pixels[i]  = FIXED_CONV[t][47:32];
					e.weights[i] = FIXED_CONV[t][31:16];
				end else if (t == 5) begin
					e.pixels[i] = e.pixels[i] | 16'h8000;  // Negative window
				end
			end
			if (t < 4) begin
				e.op   = cnn_pkg::OP_CONV;
				e.bias = FIXED_CONV[t][15:0];
			end else if (t < 6) begin
				e.op = cnn_pkg::OP_POOL;
			end
			e.result    = expected_value(e);
			test_tab[t] = e;
		end
	endtask

	task automatic wait_block_ready(output bit ok);
		int n;
		n = 0;
		while (!in_block_ready && n < READY_TIMEOUT) begin
			@(negedge okClk);
			n++;
		end
		ok = in_block_ready;
	endtask

	// Header then one pixel/weight word per window position
	task automatic send_job(input entry_t e);
		host_pkg::header_t  hdr;
		host_pkg::operand_t opd;
		hdr = '{rsvd: '0, op: e.op, bias: e.bias};
		for (int w = 0; w < host_pkg::JOB_WORDS; w++) begin
			if (($random(seed) & 7) == 0) begin
				@(negedge okClk);                   // Idle gap inside the block
			end
			if (w == 0) begin
				in_data = hdr;
			end else begin
				opd     = '{pixel: e.pixels[w-1], weight: e.weights[w-1]};
				in_data = opd;
			end
			in_valid = 1'b1;
			@(negedge okClk);
			in_valid = 1'b0;
		end
	endtask

	task automatic check_result();
		host_pkg::result_t exp_word;
		bit                good;
		assert (rx_idx < N_TESTS) else begin
			$display("unexpected result %h after the last test", out_data);
			errors++;
		end
		if (rx_idx < N_TESTS) begin
			exp_word = '{rsvd: '0, op: test_tab[rx_idx].op, value: test_tab[rx_idx].result};
			good     = (out_data == exp_word);
			assert (good) else begin
				$display("mismatch out_data in test %0d: got %h, expected %h",
					rx_idx, out_data, exp_word);
				errors++;
			end
			$display("test %0d %s: %s", rx_idx, test_tab[rx_idx].op.name(),
				good ? "pass" : "fail");
			rx_idx++;
		end
	endtask

	//--------------------------------------------------
	// Host output side with long out_ready low stretches
	//--------------------------------------------------
	initial begin : collect_results
		int stretch;
		bit low_phase;
		stretch   = 0;
		low_phase = 1'b1;
		forever begin
			@(negedge okClk);
			if (rst_n) begin
				if (stretch == 0) begin
					low_phase = !low_phase;
					stretch   = low_phase ? 40 + ($random(ready_seed) & 127)
						: 2 + ($random(ready_seed) & 7);
				end
				stretch--;
				out_ready = !low_phase;
				if (in_block_ready) begin
					throttle_opened = 1'b1;
				end else if (throttle_opened) begin
					throttle_closed = 1'b1;
				end
				if (out_valid && out_ready) begin
					check_result();             // Transfer on the coming rising edge
				end
			end
		end
	end

	initial begin : run_tests
		bit ok;
		int n;
		rst_n     = 1'b0;
		in_valid  = 1'b0;
		in_data   = '0;
		out_ready = 1'b0;
		build_table();
		repeat (16) @(negedge okClk);
		rst_n = 1'b1;
		@(negedge okClk);
		assert (!out_valid) else begin
			$display("mismatch out_valid after reset: got %h, expected 0", out_valid);
			errors++;
		end
		assert (in_block_ready) else begin
			$display("mismatch in_block_ready one cycle after reset: got %h, expected 1",
				in_block_ready);
			errors++;
		end
		$display("reset: %s", (errors == 0) ? "pass" : "fail");

		ok = 1'b1;
		for (int t = 0; t < N_TESTS && ok; t++) begin
			wait_block_ready(ok);
			if (ok) begin
				send_job(test_tab[t]);
			end else begin
				$display("timeout waiting for in_block_ready before test %0d", t);
				errors++;
			end
		end

		n = 0;
		while (rx_idx < N_TESTS && n < DRAIN_TIMEOUT) begin
			@(negedge okClk);
			n++;
		end
		assert (rx_idx == N_TESTS) else begin
			$display("timeout with %0d of %0d results received", rx_idx, N_TESTS);
			errors++;
		end
		repeat (200) @(negedge okClk);          // Room for a stray extra result
		assert (throttle_closed) else begin
			$display("in_block_ready never fell under back-pressure");
			errors++;
		end

		$display("%0d tests, %0d results, %0d errors", N_TESTS, rx_idx, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: test/cnn_top_assert.sv
`timescale 1ns/1ns
`default_nettype none

module cnn_top_assert #(
	parameter int IN_DEPTH  = 32,
	parameter int OUT_DEPTH = 8
) (
	input wire                               okClk,
	input wire                               rst_n,
	input wire                               in_valid,
	input wire [$clog2(IN_DEPTH + 1)-1:0]    in_free,
	input wire                               res_push,
	input wire [$clog2(OUT_DEPTH + 1)-1:0]   out_free,
	input wire [$clog2(OUT_DEPTH + 1)-1:0]   credits,
	input wire                               out_valid
);

	// Host keeps to the block throttle
	in_no_overflow: assert property (@(posedge okClk) disable iff (!rst_n)
		in_valid |-> in_free != '0)
		else $error("host word written into a full input FIFO");

	// Credits guarantee a free slot for every core result
	out_no_overflow: assert property (@(posedge okClk) disable iff (!rst_n)
		res_push |-> out_free != '0)
		else $error("core result pushed into a full output FIFO");

	credit_range: assert property (@(posedge okClk) disable iff (!rst_n)
		credits <= OUT_DEPTH)
		else $error("credit count above the output FIFO depth");

	out_quiet_after_reset: assert property (@(posedge okClk)
		$rose(rst_n) |-> !out_valid)
		else $error("out_valid high in the first cycle after reset");

endmodule

bind cnn_top cnn_top_assert #(
	.IN_DEPTH  (IN_DEPTH),
	.OUT_DEPTH (OUT_DEPTH)
) u_cnn_top_assert (
	.okClk     (okClk),
	.rst_n     (rst_n),
	.in_valid  (in_valid),
	.in_free   (in_free),
	.res_push  (res_push),
	.out_free  (out_free),
	.credits   (u_job_loader.credits),
	.out_valid (out_valid)
);

`default_nettype wire
